/* src.f */
src/jtag_pkg.sv
src/dbg_reg_pkg.sv
src/jtag_tap.sv
src/dbg_regs.sv
src/prbs_checker.sv
src/jtag_debug.sv
tb/jtag_debug_assert.sv
tb/jtag_debug_check.sv
tb/tb_jtag_debug.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_jtag_debug -o tb_sim \
	> build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* tb/tb_jtag_debug.sv */
`timescale 1ns/1ps

module tb_jtag_debug;
	localparam logic [31:0] IDCODE_EXP  = 32'h1deb_014b;
	// One DR scan is under 40 TCK periods of 16 clk cycles
	localparam int          SCAN_CYCLES = 40 * 16;
	localparam int          TEST_CYCLES = 20 * SCAN_CYCLES;
	localparam int          TIMEOUT     = 6 * TEST_CYCLES + 5000;

	logic        clk;
	logic        rst_i;
	logic        tck_r;
	logic        tms_r;
	logic        tdi_r;
	logic        tdo_w;
	logic        rx_bit_r;
	logic        rx_valid_r;
	logic        int_rstb_w;
	logic        en_ext_pi_w;
	logic [15:0] kp_w;
	logic [15:0] ki_w;
	logic [15:0] ext_pi_w;
	logic [31:0] lfsr;
	logic [6:0]  prbs_h;
	int          cycles;

	jtag_debug i_dut (
		.clk(clk), .rst_i(rst_i),
		.tck_i(tck_r), .tms_i(tms_r), .tdi_i(tdi_r), .tdo_o(tdo_w),
		.rx_bit_i(rx_bit_r), .rx_valid_i(rx_valid_r),
		.int_rstb_o(int_rstb_w), .en_ext_pi_ctl_o(en_ext_pi_w),
		.kp_o(kp_w), .ki_o(ki_w), .ext_pi_ctl_o(ext_pi_w)
	);

	jtag_debug_check i_check (
		.clk(clk), .rst_i(rst_i),
		.rx_bit_i(rx_bit_r), .rx_valid_i(rx_valid_r),
		.int_rstb_i(int_rstb_w), .en_ext_pi_ctl_i(en_ext_pi_w),
		.kp_i(kp_w), .ki_i(ki_w), .ext_pi_ctl_i(ext_pi_w)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		cycles = 0;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: run did not finish within %0d clock cycles", TIMEOUT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// TDO is sampled late in the low phase just before the rise
	task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
		tms_r = tms;
		tdi_r = tdi;
		step(8);
		tdo = tdo_w;
		tck_r = 1'b1;
		step(8);
		tck_r = 1'b0;
	endtask

	task automatic tap_reset();
		logic b;
		repeat (5) tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic scan_ir(input logic [3:0] ir);
		logic b;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < 4; i++) begin
			tck_cycle(i == 3, ir[i], b);
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic scan_dr(input logic [31:0] din, output logic [31:0] dout);
		logic b;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < 32; i++) begin
			tck_cycle(i == 31, din[i], b);
			dout[i] = b;
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic write_reg(input logic [6:0] addr, input logic [15:0] data);
		logic [31:0] dout;
		scan_dr({8'h00, 1'b1, addr, data}, dout);
		i_check.model_write(addr, data);
	endtask

	// Second scan returns the data latched by the first
	task automatic read_reg(input logic [6:0] addr, output logic [15:0] data);
		logic [31:0] dout;
		scan_dr({8'h00, 1'b0, addr, 16'h0000}, dout);
		scan_dr({8'h00, 1'b0, addr, 16'h0000}, dout);
		data = dout[15:0];
	endtask

	task automatic read_check(input string name, input logic [6:0] addr);
		logic [15:0] data;
		read_reg(addr, data);
		i_check.check_read(name, addr, data);
	endtask

	task automatic read_counts(input string name, output logic [31:0] total,
		output logic [31:0] correct);
		logic [15:0] lo;
		logic [15:0] hi;
		read_reg(dbg_reg_pkg::ADDR_TOTAL_LO, lo);
		i_check.check_read(name, dbg_reg_pkg::ADDR_TOTAL_LO, lo);
		read_reg(dbg_reg_pkg::ADDR_TOTAL_HI, hi);
		i_check.check_read(name, dbg_reg_pkg::ADDR_TOTAL_HI, hi);
		total = {hi, lo};
		read_reg(dbg_reg_pkg::ADDR_CORRECT_LO, lo);
		i_check.check_read(name, dbg_reg_pkg::ADDR_CORRECT_LO, lo);
		read_reg(dbg_reg_pkg::ADDR_CORRECT_HI, hi);
		i_check.check_read(name, dbg_reg_pkg::ADDR_CORRECT_HI, hi);
		correct = {hi, lo};
	endtask

	// PRBS7 source with random valid gaps and about one error in 16 bits
	task automatic stream_bits(input int n, input logic inject);
		logic [31:0] r;
		logic        nb;
		for (int i = 0; i < n; i++) begin
			rand_bits(2, r);
			if (r[1:0] != 2'b00) begin
				nb = prbs_h[6] ^ prbs_h[5];
				prbs_h = {prbs_h[5:0], nb};
				rand_bits(4, r);
				rx_bit_r = (inject && r[3:0] == 4'h0) ? ~nb : nb;
				rx_valid_r = 1'b1;
			end else begin
				rand_bits(1, r);
				rx_bit_r = r[0];
				rx_valid_r = 1'b0;
			end
			step(1);
		end
		rx_valid_r = 1'b0;
		step(2);
	endtask

	function automatic logic [15:0] ctrl_word(input logic [1:0] mode);
		return {12'h000, mode, 1'b0, 1'b1};
	endfunction

	initial begin
		logic [31:0] din;
		logic [31:0] dout;
		logic [31:0] r;
		logic [31:0] total;
		logic [31:0] correct;
		logic [15:0] wr [4];

		rst_i = 1'b1;
		tck_r = 1'b0;
		tms_r = 1'b1;
		tdi_r = 1'b0;
		rx_bit_r = 1'b0;
		rx_valid_r = 1'b0;
		lfsr = 32'h900a;
		prbs_h = 7'h7f;
		step(5);
		rst_i = 1'b0;
		step(2);

		i_check.check_outputs("reset");
		// Leave Test-Logic-Reset for Run-Test-Idle before the scan
		tap_reset();
		scan_dr(32'h0, dout);
		i_check.check_idcode("reset idcode", IDCODE_EXP, dout);
		i_check.end_test("reset");

		tap_reset();
		scan_ir(jtag_pkg::IR_BYPASS);
		rand_bits(32, din);
		scan_dr(din, dout);
		i_check.check_word("bypass", {din[30:0], 1'b0}, dout);
		i_check.end_test("bypass");

		scan_ir(jtag_pkg::IR_DBG_ACCESS);
		for (int a = 0; a < 4; a++) begin
			rand_bits(16, r);
			wr[a] = r[15:0];
			write_reg(7'(a), wr[a]);
		end
		i_check.check_outputs("cfg write");
		for (int a = 0; a < 4; a++) begin
			read_check("cfg readback", 7'(a));
		end
		i_check.end_test("cfg write");

		write_reg(dbg_reg_pkg::ADDR_TOTAL_LO, 16'hffff);
		write_reg(dbg_reg_pkg::ADDR_CORRECT_HI, 16'h5a5a);
		read_check("ro counter", dbg_reg_pkg::ADDR_TOTAL_LO);
		read_check("ro counter", dbg_reg_pkg::ADDR_CORRECT_HI);
		read_check("unmapped", 7'h05);
		read_check("unmapped", 7'h20);
		read_check("unmapped", 7'h7f);
		i_check.end_test("map");

		write_reg(dbg_reg_pkg::ADDR_CTRL, ctrl_word(2'd2));
		write_reg(dbg_reg_pkg::ADDR_CTRL, ctrl_word(2'd1));
		stream_bits(300, 1'b0);
		read_counts("prbs clean", total, correct);
		i_check.check_lock("prbs clean", total, correct);
		stream_bits(300, 1'b1);
		read_counts("prbs errors", total, correct);
		i_check.end_test("prbs run");

		write_reg(dbg_reg_pkg::ADDR_CTRL, ctrl_word(2'd2));
		read_counts("prbs clear", total, correct);
		i_check.check_word("clear total", 32'h0, total);
		write_reg(dbg_reg_pkg::ADDR_CTRL, ctrl_word(2'd1));
		stream_bits(100, 1'b1);
		write_reg(dbg_reg_pkg::ADDR_CTRL, ctrl_word(2'd0));
		stream_bits(100, 1'b1);
		read_counts("prbs hold", total, correct);
		i_check.end_test("prbs clear hold");

		$display("%0d tests ok, %0d tests failed, %0d errors",
			i_check.tests_ok, i_check.tests_failed, i_check.err_cnt);
		if (i_check.err_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* tb/jtag_debug_check.sv */
`timescale 1ns/1ps

module jtag_debug_check (
	input logic        clk,
	input logic        rst_i,
	input logic        rx_bit_i,
	input logic        rx_valid_i,
	input logic        int_rstb_i,
	input logic        en_ext_pi_ctl_i,
	input logic [15:0] kp_i,
	input logic [15:0] ki_i,
	input logic [15:0] ext_pi_ctl_i
);
	logic [15:0] ctrl_m;
	logic [15:0] kp_m;
	logic [15:0] ki_m;
	logic [15:0] ext_pi_m;
	logic [6:0]  hist_m;
	logic [31:0] total_m;
	logic [31:0] correct_m;
	logic [1:0]  mode_m;
	int          err_cnt;
	int          err_at_start;
	int          tests_ok;
	int          tests_failed;

	initial begin
		ctrl_m       = dbg_reg_pkg::RST_CTRL;
		kp_m         = dbg_reg_pkg::RST_KP;
		ki_m         = dbg_reg_pkg::RST_KI;
		ext_pi_m     = dbg_reg_pkg::RST_EXT_PI;
		err_cnt      = 0;
		err_at_start = 0;
		tests_ok     = 0;
		tests_failed = 0;
	end

	assign mode_m = ctrl_m[dbg_reg_pkg::CTRL_PRBS_MODE +: 2];

	// PRBS7 reference that counts only in RUN
	always @(posedge clk) begin
		if (rst_i) begin
			hist_m    <= '0;
			total_m   <= '0;
			correct_m <= '0;
		end else begin
			if (rx_valid_i) begin
				hist_m <= {hist_m[5:0], rx_bit_i};
			end
			if (mode_m == 2'd1 && rx_valid_i) begin
				total_m <= total_m + 32'd1;
				if (rx_bit_i == (hist_m[6] ^ hist_m[5])) begin
					correct_m <= correct_m + 32'd1;
				end
			end else if (mode_m == 2'd2) begin
				total_m   <= '0;
				correct_m <= '0;
			end
		end
	end

	task automatic model_write(input logic [6:0] addr, input logic [15:0] data);
		case (addr)
			dbg_reg_pkg::ADDR_CTRL:   ctrl_m = data;
			dbg_reg_pkg::ADDR_KP:     kp_m = data;
			dbg_reg_pkg::ADDR_KI:     ki_m = data;
			dbg_reg_pkg::ADDR_EXT_PI: ext_pi_m = data;
			default: ;
		endcase
	endtask

	function automatic logic [15:0] model_read(input logic [6:0] addr);
		case (addr)
			dbg_reg_pkg::ADDR_CTRL:       return ctrl_m;
			dbg_reg_pkg::ADDR_KP:         return kp_m;
			dbg_reg_pkg::ADDR_KI:         return ki_m;
			dbg_reg_pkg::ADDR_EXT_PI:     return ext_pi_m;
			dbg_reg_pkg::ADDR_TOTAL_LO:   return total_m[15:0];
			dbg_reg_pkg::ADDR_TOTAL_HI:   return total_m[31:16];
			dbg_reg_pkg::ADDR_CORRECT_LO: return correct_m[15:0];
			dbg_reg_pkg::ADDR_CORRECT_HI: return correct_m[31:16];
			default:                      return 16'h0000;
		endcase
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	// IDCODE fields, LSB fixed at one by IEEE 1149.1
	task automatic check_idcode(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		jtag_pkg::dr_word_u e;
		jtag_pkg::dr_word_u a;
		e = exp;
		a = act;
		check_word({name, " version"}, 32'(e.id.version), 32'(a.id.version));
		check_word({name, " part"}, 32'(e.id.part), 32'(a.id.part));
		check_word({name, " manufacturer"}, 32'(e.id.manuf), 32'(a.id.manuf));
		check_word({name, " marker"}, 32'h1, 32'(a.id.one));
	endtask

	task automatic check_read(input string name, input logic [6:0] addr, input logic [15:0] act);
		check_word($sformatf("%s addr %h", name, addr), {16'h0, model_read(addr)}, {16'h0, act});
	endtask

	task automatic check_outputs(input string name);
		check_word({name, " int_rstb"}, 32'(ctrl_m[dbg_reg_pkg::CTRL_INT_RSTB]),
			32'(int_rstb_i));
		check_word({name, " en_ext_pi"}, 32'(ctrl_m[dbg_reg_pkg::CTRL_EN_EXT_PI]),
			32'(en_ext_pi_ctl_i));
		check_word({name, " kp"}, {16'h0, kp_m}, {16'h0, kp_i});
		check_word({name, " ki"}, {16'h0, ki_m}, {16'h0, ki_i});
		check_word({name, " ext_pi"}, {16'h0, ext_pi_m}, {16'h0, ext_pi_ctl_i});
	endtask

	// Self-synchronizing check may miss at most the first 7 bits
	task automatic check_lock(input string name, input logic [31:0] total,
		input logic [31:0] correct);
		if (total - correct > 32'd7) begin
			$display("%s: correct count %0d lags total %0d by more than 7 bits",
				name, correct, total);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name);
		if (err_cnt == err_at_start) begin
			$display("test %s: ok", name);
			tests_ok++;
		end else begin
			$display("test %s: failed with %0d errors", name, err_cnt - err_at_start);
			tests_failed++;
		end
		err_at_start = err_cnt;
	endtask

endmodule

/* tb/jtag_debug_assert.sv */
`timescale 1ns/1ps

module jtag_debug_assert (
	input logic       clk,
	input logic       rst_i,
	input logic       reg_req_i,
	input logic [3:0] state_i,
	input logic       tdo_i
);
	// Strobe is a single cycle wide
	assert property (@(posedge clk) disable iff (rst_i) reg_req_i |=> !reg_req_i)
		else $error("reg_req_o stayed high for more than one cycle");

	// Strobe follows entry into Update-DR
	assert property (@(posedge clk) disable iff (rst_i)
		reg_req_i |-> (state_i == jtag_pkg::UPDATE_DR))
		else $error("reg_req_o pulsed outside Update-DR");

	assert property (@(posedge clk) disable iff (rst_i) !$isunknown(tdo_i))
		else $error("tdo_o is unknown after reset");

endmodule

bind jtag_tap jtag_debug_assert i_assert (
	.clk(clk),
	.rst_i(rst_i),
	.reg_req_i(reg_req_o),
	.state_i(state_q),
	.tdo_i(tdo_o)
);

/* src/jtag_debug.sv */
`timescale 1ns/1ps

module jtag_debug (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        tck_i,
	input  logic        tms_i,
	input  logic        tdi_i,
	output logic        tdo_o,
	input  logic        rx_bit_i,
	input  logic        rx_valid_i,
	output logic        int_rstb_o,
	output logic        en_ext_pi_ctl_o,
	output logic [15:0] kp_o,
	output logic [15:0] ki_o,
	output logic [15:0] ext_pi_ctl_o
);
	localparam logic [31:0] IDCODE_VALUE = 32'h1deb_014b;
	localparam int          CNT_WIDTH    = 32;

	logic                 reg_req;
	logic                 reg_we;
	logic [6:0]           reg_addr;
	logic [15:0]          reg_wdata;
	logic [15:0]          reg_rdata;
	logic [1:0]           prbs_mode;
	logic [CNT_WIDTH-1:0] total_cnt;
	logic [CNT_WIDTH-1:0] correct_cnt;

	jtag_tap #(.IDCODE_VALUE(IDCODE_VALUE)) i_tap (
		.clk(clk), .rst_i(rst_i),
		.tck_i(tck_i), .tms_i(tms_i), .tdi_i(tdi_i), .tdo_o(tdo_o),
		.reg_req_o(reg_req), .reg_we_o(reg_we), .reg_addr_o(reg_addr),
		.reg_wdata_o(reg_wdata), .reg_rdata_i(reg_rdata)
	);

	dbg_regs #(.CNT_WIDTH(CNT_WIDTH)) i_regs (
		.clk(clk), .rst_i(rst_i),
		.reg_req_i(reg_req), .reg_we_i(reg_we), .reg_addr_i(reg_addr),
		.reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
		.total_cnt_i(total_cnt), .correct_cnt_i(correct_cnt), .prbs_mode_o(prbs_mode),
		.int_rstb_o(int_rstb_o), .en_ext_pi_ctl_o(en_ext_pi_ctl_o),
		.kp_o(kp_o), .ki_o(ki_o), .ext_pi_ctl_o(ext_pi_ctl_o)
	);

	prbs_checker #(.CNT_WIDTH(CNT_WIDTH)) i_prbs (
		.clk(clk), .rst_i(rst_i),
		.rx_bit_i(rx_bit_i), .rx_valid_i(rx_valid_i), .mode_i(prbs_mode),
		.total_cnt_o(total_cnt), .correct_cnt_o(correct_cnt)
	);

endmodule

/* src/prbs_checker.sv */
`timescale 1ns/1ps

module prbs_checker #(
	parameter int CNT_WIDTH = 32
) (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 rx_bit_i,
	input  logic                 rx_valid_i,
	input  logic [1:0]           mode_i,
	output logic [CNT_WIDTH-1:0] total_cnt_o,
	output logic [CNT_WIDTH-1:0] correct_cnt_o
);
	// Newest received bit in position 0
	logic [6:0] hist_q;
	logic       bit_ok;

	// x^7 + x^6 + 1 predicted from the received bits themselves
	assign bit_ok = rx_bit_i == (hist_q[6] ^ hist_q[5]);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			hist_q        <= '0;
			total_cnt_o   <= '0;
			correct_cnt_o <= '0;
		end else begin
			if (rx_valid_i) begin
				hist_q <= {hist_q[5:0], rx_bit_i};
			end
			case (dbg_reg_pkg::prbs_mode_e'(mode_i))
				dbg_reg_pkg::RUN: begin
					if (rx_valid_i) begin
						total_cnt_o <= total_cnt_o + 1'b1;
						if (bit_ok) begin
							correct_cnt_o <= correct_cnt_o + 1'b1;
						end
					end
				end
				dbg_reg_pkg::CLEAR: begin
					total_cnt_o   <= '0;
					correct_cnt_o <= '0;
				end
				// Hold counts
				default: ;
			endcase
		end
	end

endmodule

/* src/dbg_regs.sv */
`timescale 1ns/1ps

module dbg_regs #(
	parameter int CNT_WIDTH = 32
) (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 reg_req_i,
	input  logic                 reg_we_i,
	input  logic [6:0]           reg_addr_i,
	input  logic [15:0]          reg_wdata_i,
	output logic [15:0]          reg_rdata_o,
	input  logic [CNT_WIDTH-1:0] total_cnt_i,
	input  logic [CNT_WIDTH-1:0] correct_cnt_i,
	output logic [1:0]           prbs_mode_o,
	output logic                 int_rstb_o,
	output logic                 en_ext_pi_ctl_o,
	output logic [15:0]          kp_o,
	output logic [15:0]          ki_o,
	output logic [15:0]          ext_pi_ctl_o
);
	localparam int HALF = CNT_WIDTH / 2;

	logic [15:0] ctrl_q;
	logic [15:0] kp_q;
	logic [15:0] ki_q;
	logic [15:0] ext_pi_q;
	logic [15:0] rd_mux;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ctrl_q   <= dbg_reg_pkg::RST_CTRL;
			kp_q     <= dbg_reg_pkg::RST_KP;
			ki_q     <= dbg_reg_pkg::RST_KI;
			ext_pi_q <= dbg_reg_pkg::RST_EXT_PI;
		end else if (reg_req_i && reg_we_i) begin
			case (reg_addr_i)
				dbg_reg_pkg::ADDR_CTRL:   ctrl_q   <= reg_wdata_i;
				dbg_reg_pkg::ADDR_KP:     kp_q     <= reg_wdata_i;
				dbg_reg_pkg::ADDR_KI:     ki_q     <= reg_wdata_i;
				dbg_reg_pkg::ADDR_EXT_PI: ext_pi_q <= reg_wdata_i;
				default: ;
			endcase
		end
	end

	// Counter halves are read only
	always_comb begin
		case (reg_addr_i)
			dbg_reg_pkg::ADDR_CTRL:       rd_mux = ctrl_q;
			dbg_reg_pkg::ADDR_KP:         rd_mux = kp_q;
			dbg_reg_pkg::ADDR_KI:         rd_mux = ki_q;
			dbg_reg_pkg::ADDR_EXT_PI:     rd_mux = ext_pi_q;
			dbg_reg_pkg::ADDR_TOTAL_LO:   rd_mux = 16'(total_cnt_i[HALF-1:0]);
			dbg_reg_pkg::ADDR_TOTAL_HI:   rd_mux = 16'(total_cnt_i[CNT_WIDTH-1:HALF]);
			dbg_reg_pkg::ADDR_CORRECT_LO: rd_mux = 16'(correct_cnt_i[HALF-1:0]);
			dbg_reg_pkg::ADDR_CORRECT_HI: rd_mux = 16'(correct_cnt_i[CNT_WIDTH-1:HALF]);
			default:                      rd_mux = 16'h0000;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			reg_rdata_o <= 16'h0000;
		end else if (reg_req_i && !reg_we_i) begin
			reg_rdata_o <= rd_mux;
		end
	end

	assign int_rstb_o      = ctrl_q[dbg_reg_pkg::CTRL_INT_RSTB];
	assign en_ext_pi_ctl_o = ctrl_q[dbg_reg_pkg::CTRL_EN_EXT_PI];
	assign prbs_mode_o     = ctrl_q[dbg_reg_pkg::CTRL_PRBS_MODE +: 2];
	assign kp_o            = kp_q;
	assign ki_o            = ki_q;
	assign ext_pi_ctl_o    = ext_pi_q;

endmodule

/* src/jtag_tap.sv */
`timescale 1ns/1ps

module jtag_tap #(
	parameter logic [31:0] IDCODE_VALUE = 32'h0000_0001
) (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        tck_i,
	input  logic        tms_i,
	input  logic        tdi_i,
	output logic        tdo_o,
	output logic        reg_req_o,
	output logic        reg_we_o,
	output logic [6:0]  reg_addr_o,
	output logic [15:0] reg_wdata_o,
	input  logic [15:0] reg_rdata_i
);
	// Bit 2 tck, bit 1 tms, bit 0 tdi
	logic [2:0] pin_meta;
	logic [2:0] pin_sync;
	logic       tck_prev;
	logic       tck_rise;
	logic       tck_fall;
	logic       tms;
	logic       tdi;

	jtag_pkg::tap_state_e state_q;
	jtag_pkg::tap_state_e state_d;

	logic [jtag_pkg::IR_WIDTH-1:0] ir_sr;
	logic [jtag_pkg::IR_WIDTH-1:0] ir_q;
	logic                          bypass_q;
	logic                          dr_sel;
	jtag_pkg::dr_word_u            dr_sr;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pin_meta <= '0;
			pin_sync <= '0;
			tck_prev <= 1'b0;
		end else begin
			pin_meta <= {tck_i, tms_i, tdi_i};
			pin_sync <= pin_meta;
			tck_prev <= pin_sync[2];
		end
	end

	assign tck_rise = pin_sync[2] & ~tck_prev;
	assign tck_fall = ~pin_sync[2] & tck_prev;
	assign tms      = pin_sync[1];
	assign tdi      = pin_sync[0];

	always_comb begin
		case (state_q)
			jtag_pkg::TEST_LOGIC_RESET:
				state_d = tms ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::RUN_TEST_IDLE: state_d = tms ? jtag_pkg::SELECT_DR : jtag_pkg::RUN_TEST_IDLE;
			jtag_pkg::SELECT_DR:     state_d = tms ? jtag_pkg::SELECT_IR : jtag_pkg::CAPTURE_DR;
			jtag_pkg::CAPTURE_DR:    state_d = tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::SHIFT_DR:      state_d = tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::EXIT1_DR:      state_d = tms ? jtag_pkg::UPDATE_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::PAUSE_DR:      state_d = tms ? jtag_pkg::EXIT2_DR : jtag_pkg::PAUSE_DR;
			jtag_pkg::EXIT2_DR:      state_d = tms ? jtag_pkg::UPDATE_DR : jtag_pkg::SHIFT_DR;
			jtag_pkg::SELECT_IR:
				state_d = tms ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::CAPTURE_IR;
			jtag_pkg::CAPTURE_IR:    state_d = tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::SHIFT_IR:      state_d = tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
			jtag_pkg::EXIT1_IR:      state_d = tms ? jtag_pkg::UPDATE_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::PAUSE_IR:      state_d = tms ? jtag_pkg::EXIT2_IR : jtag_pkg::PAUSE_IR;
			jtag_pkg::EXIT2_IR:      state_d = tms ? jtag_pkg::UPDATE_IR : jtag_pkg::SHIFT_IR;
			// Both update states leave the same way
			default:                 state_d = tms ? jtag_pkg::SELECT_DR : jtag_pkg::RUN_TEST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= jtag_pkg::TEST_LOGIC_RESET;
			ir_q    <= jtag_pkg::IR_IDCODE;
		end else if (tck_rise) begin
			state_q <= state_d;
			if (state_d == jtag_pkg::TEST_LOGIC_RESET) begin
				ir_q <= jtag_pkg::IR_IDCODE;
			end else if (state_d == jtag_pkg::UPDATE_IR) begin
				ir_q <= ir_sr;
			end
		end
	end

	assign dr_sel = (ir_q == jtag_pkg::IR_IDCODE) || (ir_q == jtag_pkg::IR_DBG_ACCESS);

	// Capture and shift on the rising edge
	always_ff @(posedge clk) begin
		if (tck_rise) begin
			case (state_q)
				jtag_pkg::CAPTURE_IR: ir_sr <= 4'b0101;
				jtag_pkg::SHIFT_IR:   ir_sr <= {tdi, ir_sr[jtag_pkg::IR_WIDTH-1:1]};
				jtag_pkg::CAPTURE_DR: begin
					bypass_q <= 1'b0;
					if (ir_q == jtag_pkg::IR_DBG_ACCESS) begin
						dr_sr <= {16'h0000, reg_rdata_i};
					end else begin
						dr_sr <= IDCODE_VALUE;
					end
				end
				jtag_pkg::SHIFT_DR: begin
					bypass_q <= tdi;
					dr_sr    <= {tdi, dr_sr[jtag_pkg::DR_WIDTH-1:1]};
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			tdo_o <= 1'b0;
		end else if (tck_fall) begin
			case (state_q)
				jtag_pkg::SHIFT_DR: tdo_o <= dr_sel ? dr_sr[0] : bypass_q;
				jtag_pkg::SHIFT_IR: tdo_o <= ir_sr[0];
				default:            tdo_o <= 1'b0;
			endcase
		end
	end

	// One strobe per entry into Update-DR
	always_ff @(posedge clk) begin
		if (rst_i) begin
			reg_req_o <= 1'b0;
		end else begin
			reg_req_o <= tck_rise && (state_d == jtag_pkg::UPDATE_DR) &&
				(ir_q == jtag_pkg::IR_DBG_ACCESS);
		end
	end

	assign reg_we_o    = dr_sr.cmd.we;
	assign reg_addr_o  = dr_sr.cmd.addr;
	assign reg_wdata_o = dr_sr.cmd.data;

endmodule

/* src/dbg_reg_pkg.sv */
package dbg_reg_pkg;

	localparam logic [6:0] ADDR_CTRL       = 7'h00;
	localparam logic [6:0] ADDR_KP         = 7'h01;
	localparam logic [6:0] ADDR_KI         = 7'h02;
	localparam logic [6:0] ADDR_EXT_PI     = 7'h03;
	localparam logic [6:0] ADDR_TOTAL_LO   = 7'h10;
	localparam logic [6:0] ADDR_TOTAL_HI   = 7'h11;
	localparam logic [6:0] ADDR_CORRECT_LO = 7'h12;
	localparam logic [6:0] ADDR_CORRECT_HI = 7'h13;

	// CTRL fields, mode is two bits wide from its position
	localparam int CTRL_INT_RSTB  = 0;
	localparam int CTRL_EN_EXT_PI = 1;
	localparam int CTRL_PRBS_MODE = 2;

	typedef enum logic [1:0] {
		OFF   = 2'd0,
		RUN   = 2'd1,
		CLEAR = 2'd2
	} prbs_mode_e;

	localparam logic [15:0] RST_CTRL   = 16'h0000;
	localparam logic [15:0] RST_KP     = 16'h0010;
	localparam logic [15:0] RST_KI     = 16'h0002;
	localparam logic [15:0] RST_EXT_PI = 16'h0000;

endpackage

/* src/jtag_pkg.sv */
package jtag_pkg;

	// IEEE 1149.1 controller states
	typedef enum logic [3:0] {
		TEST_LOGIC_RESET, RUN_TEST_IDLE, SELECT_DR, CAPTURE_DR,
		SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR,
		UPDATE_DR, SELECT_IR, CAPTURE_IR, SHIFT_IR,
		EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
	} tap_state_e;

	localparam int IR_WIDTH = 4;
	localparam logic [IR_WIDTH-1:0] IR_IDCODE     = 4'h1;
	localparam logic [IR_WIDTH-1:0] IR_DBG_ACCESS = 4'h8;
	localparam logic [IR_WIDTH-1:0] IR_BYPASS     = 4'hf;

	localparam int DR_WIDTH = 32;

	typedef struct packed {
		logic [7:0]  unused;
		logic        we;
		logic [6:0]  addr;
		logic [15:0] data;
	} dbg_cmd_t;

	typedef struct packed {
		logic [3:0]  version;
		logic [15:0] part;
		logic [10:0] manuf;
		logic        one;
	} idcode_t;

	// Same scan word, command or identification view
	typedef union packed {
		dbg_cmd_t cmd;
		idcode_t  id;
	} dr_word_u;

endpackage
